/* vlog.f */
+incdir+hw
hw/bp_pkg.sv
hw/instr_classify.sv
hw/btb.sv
hw/global_predictor.sv
hw/local_predictor.sv
hw/meta_chooser.sv
hw/return_stack.sv
hw/hybrid_predictor.sv
tests/tb_clock_gen.sv
tests/hybrid_predictor_checker.sv
tests/tb_hybrid_predictor.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_hybrid_predictor
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_hybrid_predictor.sv */
`timescale 1ns/100ps
`include "bp_settings.svh"

module tb_hybrid_predictor;

    typedef struct packed {
        logic        flush;
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] r_instr;
        logic [31:0] r_addr;
        logic        r_taken;
        logic [31:0] r_target;
        logic [1:0]  r_preds;
        logic        e_taken;
        logic [31:0] e_addr;
        logic [1:0]  e_preds;
    } row_t;

    localparam logic [31:0] FILL   = 32'hFFFF_FFFF;  // Slot gets a random non-branch word.
    localparam logic [31:0] NOP    = 32'h0000_0000;
    localparam logic [31:0] J_A    = 32'h0800_1800;
    localparam logic [31:0] JAL_C  = 32'h0C00_1C00;
    localparam logic [31:0] BEQ_B  = 32'h1000_0010;
    localparam logic [31:0] BNE_D  = 32'h1420_0008;
    localparam logic [31:0] RET    = 32'h03E0_0008;  // JR $31.
    localparam logic [31:0] PC_A   = 32'h0000_3200;
    localparam logic [31:0] PC_B   = 32'h0000_1040;
    localparam logic [31:0] PC_C   = 32'h0000_4308;
    localparam logic [31:0] PC_D   = 32'h0000_2280;
    localparam logic [31:0] PC_R   = 32'h0000_5404;
    localparam logic [31:0] PC_F   = 32'h0000_2114;  // Index is PC_B's XOR 0x55, never trained.
    localparam logic [31:0] TGT_A  = 32'h0000_6000;
    localparam logic [31:0] TGT_B  = 32'h0000_1084;
    localparam logic [31:0] TGT_C  = 32'h0000_7000;
    localparam logic [31:0] TGT_D  = 32'h0000_22A4;
    localparam logic [31:0] RET_C  = PC_C + 32'd4;

    logic        CLK;
    logic        RESET;
    logic        flush;
    logic [31:0] instr;
    logic [31:0] instr_addr;
    logic [31:0] res_instr;
    logic [31:0] res_addr;
    logic        res_taken;
    logic [31:0] res_target;
    logic [1:0]  res_predictions;
    logic        taken;
    logic [31:0] taken_addr;
    logic [1:0]  predictions;

    row_t   stim_q[$];
    integer seed = 86675;
    int     timeout_ns;
    logic   table_ready = 1'b0;

    tb_clock_gen i_tb_clock_gen (.CLK(CLK), .RESET(RESET));

    hybrid_predictor i_hybrid_predictor (
        .CLK(CLK), .RESET(RESET), .flush(flush),
        .instr(instr), .instr_addr(instr_addr),
        .res_instr(res_instr), .res_addr(res_addr), .res_taken(res_taken),
        .res_target(res_target), .res_predictions(res_predictions),
        .taken(taken), .taken_addr(taken_addr), .predictions(predictions)
    );

    //****************************************
    // Failure reporting and compares
    //****************************************
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("error: %s = 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic compare_addr(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("error: %s = 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic compare_preds(input string name, input logic [1:0] got,
                                 input logic [1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("error: %s = 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Opcodes 8 to 15 are ALU immediates.
    function automatic logic [31:0] filler_word();
        logic [31:0] word;
        word = $random(seed);
        word[31:29] = 3'b001;
        return word;
    endfunction

    //****************************************
    // Stimulus table
    //****************************************
    task automatic add_row(input logic fl, input logic [31:0] f_instr, input logic [31:0] f_pc,
                           input logic [31:0] r_instr, input logic [31:0] r_addr,
                           input logic r_taken, input logic [31:0] r_target,
                           input logic [1:0] r_preds,
                           input logic e_taken, input logic [31:0] e_addr,
                           input logic [1:0] e_preds);
        row_t row;
        row.flush    = fl;
        row.instr    = f_instr;
        row.pc       = f_pc;
        row.r_instr  = r_instr;
        row.r_addr   = r_addr;
        row.r_taken  = r_taken;
        row.r_target = r_target;
        row.r_preds  = r_preds;
        row.e_taken  = e_taken;
        row.e_addr   = e_addr;
        row.e_preds  = e_preds;
        stim_q.push_back(row);
    endtask

    task automatic add_fetch(input logic fl, input logic [31:0] f_instr, input logic [31:0] f_pc,
                             input logic e_taken, input logic [31:0] e_addr,
                             input logic [1:0] e_preds);
        add_row(fl, f_instr, f_pc, NOP, 32'd0, 1'b0, 32'd0, 2'b00, e_taken, e_addr, e_preds);
    endtask

    // Filler fetch beside a resolution, always a plain miss.
    task automatic add_resolve(input logic [31:0] r_instr, input logic [31:0] r_addr,
                               input logic r_taken, input logic [31:0] r_target);
        add_row(1'b0, FILL, PC_F, r_instr, r_addr, r_taken, r_target, 2'b00,
                1'b0, 32'd0, 2'b00);
    endtask

    task automatic build_table();
        add_fetch(1'b0, FILL, PC_F, 1'b0, 32'd0, 2'b00);     // Non-branch never taken.
        add_fetch(1'b0, J_A, PC_A, 1'b0, 32'd0, 2'b00);      // Cold BTB miss.
        add_resolve(J_A, PC_A, 1'b1, TGT_A);
        add_fetch(1'b0, J_A, PC_A, 1'b1, TGT_A, 2'b00);
        add_fetch(1'b0, FILL, PC_A, 1'b0, TGT_A, 2'b00);     // Hit, but not a branch.
        add_resolve(JAL_C, PC_C, 1'b1, TGT_C);               // Pushes C + 4.
        add_fetch(1'b0, RET, PC_R, 1'b1, RET_C, 2'b00);
        add_fetch(1'b0, JAL_C, PC_C, 1'b1, TGT_C, 2'b00);
        add_resolve(RET, PC_R, 1'b1, RET_C);                 // Pops and fills the BTB.
        add_fetch(1'b0, RET, PC_R, 1'b0, RET_C, 2'b00);      // Hit, but a return is not a jump.
        for (int k = 0; k < `BP_HIST_BITS + 2; k++) begin
            add_resolve(BEQ_B, PC_B, 1'b1, TGT_B);
        end
        add_fetch(1'b0, BEQ_B, PC_B, 1'b1, TGT_B, 2'b11);
        for (int k = 0; k < `BP_HIST_BITS + 2; k++) begin
            add_resolve(BEQ_B, PC_B, 1'b0, TGT_B);
        end
        add_fetch(1'b0, BEQ_B, PC_B, 1'b0, TGT_B, 2'b00);
        add_fetch(1'b0, J_A, PC_A, 1'b1, TGT_A, 2'b00);
        add_fetch(1'b1, J_A, PC_A, 1'b0, 32'd0, 2'b00);      // Flush.
        add_fetch(1'b0, J_A, PC_A, 1'b0, 32'd0, 2'b00);
        add_fetch(1'b0, BEQ_B, PC_B, 1'b0, 32'd0, 2'b00);
        add_fetch(1'b0, FILL, PC_F, 1'b0, 32'd0, 2'b00);
        // Global was right on a disagreement twice, so the chooser moves to global.
        add_row(1'b0, FILL, PC_F, BNE_D, PC_D, 1'b1, TGT_D, 2'b10, 1'b0, 32'd0, 2'b00);
        add_row(1'b0, FILL, PC_F, BNE_D, PC_D, 1'b1, TGT_D, 2'b10, 1'b0, 32'd0, 2'b00);
        add_fetch(1'b0, BNE_D, PC_D, 1'b0, TGT_D, 2'b01);    // Local says taken, global wins.
    endtask

    task automatic apply_row(input row_t row);
        flush           <= row.flush;
        instr           <= (row.instr == FILL) ? filler_word() : row.instr;
        instr_addr      <= row.pc;
        res_instr       <= row.r_instr;
        res_addr        <= row.r_addr;
        res_taken       <= row.r_taken;
        res_target      <= row.r_target;
        res_predictions <= row.r_preds;
    endtask

    task automatic check_row(input int idx);
        row_t row;
        row = stim_q[idx];
        compare_bit($sformatf("taken (row %0d)", idx), taken, row.e_taken);
        compare_addr($sformatf("taken_addr (row %0d)", idx), taken_addr, row.e_addr);
        compare_preds($sformatf("predictions (row %0d)", idx), predictions, row.e_preds);
    endtask

    //****************************************
    // Main sequence and watchdog
    //****************************************
    initial begin
        flush           = 1'b0;
        instr           = NOP;
        instr_addr      = 32'd0;
        res_instr       = NOP;
        res_addr        = 32'd0;
        res_taken       = 1'b0;
        res_target      = 32'd0;
        res_predictions = 2'b00;
        build_table();
        timeout_ns  = (stim_q.size() + 20) * 4;
        table_ready = 1'b1;
        wait (RESET === 1'b1);
        @(negedge CLK);
        compare_bit("taken after reset", taken, 1'b0);
        compare_addr("taken_addr after reset", taken_addr, 32'd0);
        compare_preds("predictions after reset", predictions, 2'b00);
        for (int i = 0; i < stim_q.size(); i++) begin
            @(posedge CLK);
            apply_row(stim_q[i]);
            @(negedge CLK);
            if (i > 0) begin
                check_row(i - 1);                        // Outputs lag by one cycle.
            end
        end
        @(posedge CLK);
        flush     <= 1'b0;
        instr     <= NOP;
        res_instr <= NOP;
        @(negedge CLK);
        check_row(stim_q.size() - 1);
        $display("Test OK");
        $finish;
    end

    initial begin
        wait (table_ready);
        #(timeout_ns);
        stop_run($sformatf("Watchdog: the run did not finish within %0d ns", timeout_ns));
    end

endmodule

/* tests/hybrid_predictor_checker.sv */
`timescale 1ns/100ps

module hybrid_predictor_checker (
    input logic        CLK,
    input logic        RESET,
    input logic        flush,
    input logic        btb_hit,
    input logic        ras_valid,
    input logic        taken,
    input logic [31:0] taken_addr,
    input logic [1:0]  predictions
);

    // A return stack prediction is always taken and carries no direction bits.
    ras_override: assert property (@(posedge CLK) disable iff (!RESET)
        (ras_valid && !flush) |=> (taken && predictions == 2'b00))
        else $error("return stack prediction carried direction bits");

    no_hit_no_target: assert property (@(posedge CLK) disable iff (!RESET)
        (!btb_hit && !ras_valid) |=> (!taken && taken_addr == 32'd0))
        else $error("target given without a BTB hit");

    flush_clears: assert property (@(posedge CLK) disable iff (!RESET)
        flush |=> (!taken && taken_addr == 32'd0 && predictions == 2'b00))
        else $error("outputs not cleared after flush");

endmodule

bind hybrid_predictor hybrid_predictor_checker i_hybrid_predictor_checker (
    .CLK(CLK), .RESET(RESET), .flush(flush),
    .btb_hit(btb_hit), .ras_valid(ras_valid),
    .taken(taken), .taken_addr(taken_addr), .predictions(predictions)
);

/* tests/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic CLK,
    output logic RESET
);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;                           // 4 ns period.
    end

    initial begin
        RESET = 1'b0;
        repeat (10) @(posedge CLK);
        RESET <= 1'b1;                                   // Released on a rising edge.
    end

endmodule

/* hw/hybrid_predictor.sv */
`timescale 1ns/100ps

module hybrid_predictor (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        flush,
    input  logic [31:0] instr,
    input  logic [31:0] instr_addr,
    input  logic [31:0] res_instr,
    input  logic [31:0] res_addr,
    input  logic        res_taken,
    input  logic [31:0] res_target,
    input  logic [1:0]  res_predictions,
    output logic        taken,
    output logic [31:0] taken_addr,
    output logic [1:0]  predictions
);

    bp_pkg::instr_class_e fetch_class;
    bp_pkg::instr_class_e res_class;

    logic        res_valid;
    logic        res_cond;
    logic        res_call;
    logic        res_ret;
    logic        fetch_ret;
    logic        fetch_uncond;
    logic        btb_hit;
    logic [31:0] btb_target;
    logic        global_taken;
    logic        local_taken;
    logic        use_global;
    logic        chosen_taken;
    logic        ras_valid;
    logic [31:0] ras_addr;
    logic        next_taken;
    logic [31:0] next_taken_addr;
    logic [1:0]  next_predictions;

    instr_classify i_fetch_classify (.instr(instr),     .cls(fetch_class));
    instr_classify i_res_classify   (.instr(res_instr), .cls(res_class));

    //****************************************
    // Training strobes
    //****************************************
    assign res_valid    = (res_class != bp_pkg::CLS_NONE);
    assign res_cond     = (res_class == bp_pkg::CLS_COND);
    assign res_call     = (res_class == bp_pkg::CLS_CALL);
    assign res_ret      = (res_class == bp_pkg::CLS_RETURN);
    assign fetch_ret    = (fetch_class == bp_pkg::CLS_RETURN);
    assign fetch_uncond = (fetch_class == bp_pkg::CLS_JUMP) ||
                          (fetch_class == bp_pkg::CLS_CALL);

    btb i_btb (
        .CLK(CLK), .RESET(RESET), .flush(flush),
        .lookup_addr(instr_addr), .hit(btb_hit), .target(btb_target),
        .wr_en(res_valid && res_taken), .wr_addr(res_addr), .wr_target(res_target)
    );

    global_predictor i_global_predictor (
        .CLK(CLK), .RESET(RESET),
        .lookup_addr(instr_addr), .pred_taken(global_taken),
        .train(res_cond), .train_addr(res_addr), .train_taken(res_taken)
    );

    local_predictor i_local_predictor (
        .CLK(CLK), .RESET(RESET),
        .lookup_addr(instr_addr), .pred_taken(local_taken),
        .train(res_cond), .train_addr(res_addr), .train_taken(res_taken)
    );

    // Chooser only learns when the two predictors disagreed.
    meta_chooser i_meta_chooser (
        .CLK(CLK), .RESET(RESET),
        .lookup_addr(instr_addr), .use_global(use_global),
        .train(res_cond && (res_predictions[1] != res_predictions[0])),
        .train_addr(res_addr),
        .global_correct(res_predictions[1] == res_taken)
    );

    return_stack i_return_stack (
        .CLK(CLK), .RESET(RESET),
        .push(res_call), .push_addr(res_addr + 32'd4),   // Return lands after the JAL.
        .pop(res_ret), .peek(fetch_ret),
        .valid(ras_valid), .top_addr(ras_addr)
    );

    //****************************************
    // Prediction
    //****************************************
    assign chosen_taken = use_global ? global_taken : local_taken;

    always_comb begin
        if (ras_valid) begin
            next_taken       = 1'b1;                     // Stack overrides all.
            next_taken_addr  = ras_addr;
            next_predictions = 2'b00;                    // Keeps the chooser untrained.
        end else begin
            next_taken = btb_hit &&
                         (fetch_uncond || ((fetch_class == bp_pkg::CLS_COND) && chosen_taken));
            next_taken_addr  = btb_hit ? btb_target : 32'd0;
            next_predictions = {global_taken, local_taken};
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            taken       <= 1'b0;
            taken_addr  <= 32'd0;
            predictions <= 2'b00;
        end else if (flush) begin
            taken       <= 1'b0;
            taken_addr  <= 32'd0;
            predictions <= 2'b00;
        end else begin
            taken       <= next_taken;
            taken_addr  <= next_taken_addr;
            predictions <= next_predictions;
        end
    end

endmodule

/* hw/return_stack.sv */
`timescale 1ns/100ps
`include "bp_settings.svh"

module return_stack (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        push,
    input  logic [31:0] push_addr,
    input  logic        pop,
    input  logic        peek,
    output logic        valid,
    output logic [31:0] top_addr
);

    localparam int PTR_BITS = $clog2(`BP_RAS_DEPTH);

    logic [31:0]         entries [`BP_RAS_DEPTH];
    logic [PTR_BITS-1:0] ptr;                            // Points at the top entry.
    logic [PTR_BITS:0]   count;
    logic                not_empty;

    assign not_empty = (count != '0);
    assign valid     = peek && not_empty;
    assign top_addr  = entries[ptr];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            ptr   <= '0;
            count <= '0;
        end else if (push && !(pop && not_empty)) begin
            ptr <= ptr + 1'b1;                           // Wraps and drops the oldest.
            if (count != (PTR_BITS+1)'(`BP_RAS_DEPTH)) begin
                count <= count + 1'b1;
            end
        end else if (pop && !push && not_empty) begin
            ptr   <= ptr - 1'b1;
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (push && pop && not_empty) begin
            entries[ptr] <= push_addr;                   // Replace the top.
        end else if (push) begin
            entries[ptr + 1'b1] <= push_addr;
        end
    end

endmodule

/* hw/meta_chooser.sv */
`timescale 1ns/100ps
`include "bp_settings.svh"

module meta_chooser (
    input  logic        CLK,
    input  logic        RESET,
    input  logic [31:0] lookup_addr,
    output logic        use_global,
    input  logic        train,
    input  logic [31:0] train_addr,
    input  logic        global_correct
);

    localparam int ENTRIES = 1 << `BP_META_IDX_BITS;

    logic [1:0]                   counters [ENTRIES];
    logic [`BP_META_IDX_BITS-1:0] lookup_idx;
    logic [`BP_META_IDX_BITS-1:0] train_idx;

    assign lookup_idx = lookup_addr[`BP_META_IDX_BITS+1:2];
    assign train_idx  = train_addr[`BP_META_IDX_BITS+1:2];
    assign use_global = counters[lookup_idx][1];         // Global wins at 2 or 3.

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= bp_pkg::CTR_RESET;        // Starts leaning local.
            end
        end else if (train) begin
            counters[train_idx] <= bp_pkg::ctr_update(counters[train_idx], global_correct);
        end
    end

endmodule

/* hw/local_predictor.sv */
`timescale 1ns/100ps
`include "bp_settings.svh"

module local_predictor (
    input  logic        CLK,
    input  logic        RESET,
    input  logic [31:0] lookup_addr,
    output logic        pred_taken,
    input  logic        train,
    input  logic [31:0] train_addr,
    input  logic        train_taken
);

    localparam int ENTRIES = 1 << `BP_LOCAL_IDX_BITS;

    logic [1:0]                    counters [ENTRIES];
    logic [`BP_LOCAL_IDX_BITS-1:0] lookup_idx;
    logic [`BP_LOCAL_IDX_BITS-1:0] train_idx;

    // Indexed by PC alone.
    assign lookup_idx = lookup_addr[`BP_LOCAL_IDX_BITS+1:2];
    assign train_idx  = train_addr[`BP_LOCAL_IDX_BITS+1:2];

    assign pred_taken = counters[lookup_idx][1];

    //****************************************
    // Counter training
    //****************************************
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= bp_pkg::CTR_RESET;
            end
        end else if (train) begin
            counters[train_idx] <= bp_pkg::ctr_update(counters[train_idx], train_taken);
        end
    end

endmodule

/* hw/global_predictor.sv */
`timescale 1ns/100ps
`include "bp_settings.svh"

module global_predictor (
    input  logic        CLK,
    input  logic        RESET,
    input  logic [31:0] lookup_addr,
    output logic        pred_taken,
    input  logic        train,
    input  logic [31:0] train_addr,
    input  logic        train_taken
);

    localparam int ENTRIES = 1 << `BP_HIST_BITS;

    logic [1:0]               counters [ENTRIES];
    logic [`BP_HIST_BITS-1:0] history;
    logic [`BP_HIST_BITS-1:0] lookup_idx;
    logic [`BP_HIST_BITS-1:0] train_idx;

    // Gshare index.
    assign lookup_idx = lookup_addr[`BP_HIST_BITS+1:2] ^ history;
    assign train_idx  = train_addr[`BP_HIST_BITS+1:2] ^ history;
    assign pred_taken = counters[lookup_idx][1];         // Taken at 2 or 3.

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= bp_pkg::CTR_RESET;
            end
            history <= '0;
        end else if (train) begin
            counters[train_idx] <= bp_pkg::ctr_update(counters[train_idx], train_taken);
            history <= {history[`BP_HIST_BITS-2:0], train_taken};  // Newest in bit 0.
        end
    end

endmodule

/* hw/btb.sv */
`timescale 1ns/100ps
`include "bp_settings.svh"

module btb (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        flush,
    input  logic [31:0] lookup_addr,
    output logic        hit,
    output logic [31:0] target,
    input  logic        wr_en,
    input  logic [31:0] wr_addr,
    input  logic [31:0] wr_target
);

    localparam int ENTRIES  = 1 << `BP_BTB_IDX_BITS;
    localparam int TAG_BITS = 30 - `BP_BTB_IDX_BITS;

    logic [ENTRIES-1:0]    valid;
    logic [TAG_BITS-1:0]   tags    [ENTRIES];
    logic [31:0]           targets [ENTRIES];

    logic [`BP_BTB_IDX_BITS-1:0] lookup_idx;
    logic [`BP_BTB_IDX_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0]         lookup_tag;

    assign lookup_idx = lookup_addr[`BP_BTB_IDX_BITS+1:2];
    assign lookup_tag = lookup_addr[31:`BP_BTB_IDX_BITS+2];
    assign wr_idx     = wr_addr[`BP_BTB_IDX_BITS+1:2];

    assign hit    = valid[lookup_idx] && (tags[lookup_idx] == lookup_tag);
    assign target = targets[lookup_idx];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;                                 // Flush beats a write.
        end else if (wr_en) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            tags[wr_idx]    <= wr_addr[31:`BP_BTB_IDX_BITS+2];
            targets[wr_idx] <= wr_target;
        end
    end

endmodule

/* hw/instr_classify.sv */
`timescale 1ns/100ps

module instr_classify (
    input  logic [31:0]          instr,
    output bp_pkg::instr_class_e cls
);

    bp_pkg::opcode_e opcode;
    logic [4:0]      rs;
    logic [5:0]      funct;

    assign opcode = bp_pkg::opcode_e'(instr[31:26]);
    assign rs     = instr[25:21];
    assign funct  = instr[5:0];

    always_comb begin
        cls = bp_pkg::CLS_NONE;
        case (opcode)
            bp_pkg::OP_SPECIAL: begin
                if (funct == bp_pkg::FUNCT_JR && rs == bp_pkg::REG_RA) begin
                    cls = bp_pkg::CLS_RETURN;            // JR $31.
                end
            end
            bp_pkg::OP_J:    cls = bp_pkg::CLS_JUMP;
            bp_pkg::OP_JAL:  cls = bp_pkg::CLS_CALL;
            bp_pkg::OP_BEQ,
            bp_pkg::OP_BNE,
            bp_pkg::OP_BLEZ,
            bp_pkg::OP_BGTZ: cls = bp_pkg::CLS_COND;
            default:         cls = bp_pkg::CLS_NONE;
        endcase
    end

endmodule

/* hw/bp_pkg.sv */
package bp_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,
        OP_J       = 6'd2,
        OP_JAL     = 6'd3,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_BLEZ    = 6'd6,
        OP_BGTZ    = 6'd7
    } opcode_e;

    typedef enum logic [2:0] {
        CLS_NONE,                                // Not a control transfer.
        CLS_COND,
        CLS_JUMP,
        CLS_CALL,
        CLS_RETURN                               // JR through the return address reg.
    } instr_class_e;

    localparam logic [5:0] FUNCT_JR  = 6'd8;
    localparam logic [4:0] REG_RA    = 5'd31;
    localparam logic [1:0] CTR_RESET = 2'd1;     // Weakly not taken.

    // Two-bit saturating counter step.
    function automatic logic [1:0] ctr_update(input logic [1:0] ctr, input logic up);
        logic [1:0] nxt;
        nxt = ctr;
        if (up && ctr != 2'b11) begin
            nxt = ctr + 2'd1;
        end else if (!up && ctr != 2'b00) begin
            nxt = ctr - 2'd1;
        end
        return nxt;
    endfunction

endpackage

/* hw/bp_settings.svh */
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// BTB index taken from PC[7:2].
`define BP_BTB_IDX_BITS   6

// Global history length and gshare index width.
`define BP_HIST_BITS      8

`define BP_LOCAL_IDX_BITS 8
`define BP_META_IDX_BITS  8

// Return stack entries.
`define BP_RAS_DEPTH      8

`endif
